// File: all.f
+incdir+include
hdl/frame_reader_pkg.sv
hdl/sdram_burst_reader.sv
hdl/bayer_line_demosaic.sv
hdl/cpu_pixel_port.sv
hdl/frame_reader_top.sv
tests/frame_reader_assertions.sv
tests/frame_reader_tb.sv

// File: hdl/bayer_line_demosaic.sv
`timescale 1ns/1ps

module bayer_line_demosaic (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           frame_start,
    input  frame_reader_pkg::raw_sample_t  sample,
    input  logic                           sample_valid,
    output frame_reader_pkg::rgb_pixel_t   pixel,
    output logic                           pixel_valid
);

    logic [frame_reader_pkg::COL_W-1:0] col;
    logic                               row_odd;
    logic                               is_red;
    logic                               is_blue;
    logic                               is_green;
    logic [frame_reader_pkg::PIX_W-1:0] corr;
    logic [frame_reader_pkg::PIX_W-1:0] red_lat;
    logic [frame_reader_pkg::PIX_W-1:0] green_lat;
    logic [frame_reader_pkg::PIX_W-1:0] blue_lat;

    // black level removal, clamp at zero, keep the top 8 bits
    function automatic logic [frame_reader_pkg::PIX_W-1:0] correct(
        input logic [frame_reader_pkg::RAW_W-1:0] raw
    );
        logic [frame_reader_pkg::RAW_W-1:0] diff;
        if (raw < frame_reader_pkg::RAW_W'(frame_reader_pkg::BLACK_LEVEL)) begin
            diff = '0;
        end else begin
            diff = raw - frame_reader_pkg::RAW_W'(frame_reader_pkg::BLACK_LEVEL);
        end
        return diff[frame_reader_pkg::RAW_W-1 -: frame_reader_pkg::PIX_W];
    endfunction

    // bayer phase
    // even rows R G R G, odd rows G B G B
    assign is_red   = !row_odd && !col[0];
    assign is_blue  = row_odd && col[0];
    assign is_green = !is_red && !is_blue;
    assign corr     = correct(sample.raw);

    // column and row tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col         <= '0;
            row_odd     <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= sample_valid;
            if (frame_start) begin
                col     <= '0;
                row_odd <= 1'b0;
            end else if (sample_valid) begin
                if (col == frame_reader_pkg::COL_W'(frame_reader_pkg::LINE_PIXELS - 1)) begin
                    col     <= '0;
                    row_odd <= !row_odd;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // latest value of each colour, zero until seen in this frame
    always_ff @(posedge clk) begin
        if (frame_start) begin
            red_lat   <= '0;
            green_lat <= '0;
            blue_lat  <= '0;
        end else if (sample_valid) begin
            if (is_red) begin
                red_lat <= corr;
            end
            if (is_green) begin
                green_lat <= corr;
            end
            if (is_blue) begin
                blue_lat <= corr;
            end
        end
    end

    // output pixel, current sample replaces its own colour
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            pixel.red   <= is_red ? corr : red_lat;
            pixel.green <= is_green ? corr : green_lat;
            pixel.blue  <= is_blue ? corr : blue_lat;
            pixel.last  <= sample.last;
        end
    end

endmodule

// File: hdl/cpu_pixel_port.sv
`timescale 1ns/1ps

module cpu_pixel_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  frame_reader_pkg::rgb_pixel_t  pixel,
    input  logic                          pixel_valid,
    input  logic                          empty_frame,
    input  logic                          frame_start,
    input  logic                          ack,
    input  logic                          reg_sel,
    output logic                          pixel_rdy,
    output logic                          img_done,
    output logic                          fetch,
    output frame_reader_pkg::cpu_word_u   cpu_readdata
);

    frame_reader_pkg::rgb_pixel_t held;
    logic                         busy;
    logic                         done_flag;
    logic                         ack_taken;

    // ack only counts while a pixel is offered
    assign ack_taken = ack && pixel_rdy;

    // combinational so the reader strobes on the very next edge
    assign fetch = ack_taken && !held.last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_rdy <= 1'b0;
            img_done  <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            img_done <= 1'b0;
            if (pixel_valid) begin
                pixel_rdy <= 1'b1;
            end else if (ack_taken) begin
                pixel_rdy <= 1'b0;
            end
            // frame ends on ack of the last pixel
            if (ack_taken && held.last) begin
                img_done  <= 1'b1;
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
            // empty frame, done without any fetch
            if (empty_frame) begin
                img_done  <= 1'b1;
                done_flag <= 1'b1;
            end
            if (frame_start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end
        end
    end

    // held pixel, stable until the processor acks
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            held <= pixel;
        end
    end

    // readout word
    // reg_sel low gives status, high gives the pixel
    always_comb begin
        cpu_readdata = '0;
        if (reg_sel) begin
            cpu_readdata.pix.red   = held.red;
            cpu_readdata.pix.green = held.green;
            cpu_readdata.pix.blue  = held.blue;
            cpu_readdata.pix.pad   = '0;
            cpu_readdata.pix.done  = done_flag;
        end else begin
            cpu_readdata.stat.zero      = '0;
            cpu_readdata.stat.busy      = busy;
            cpu_readdata.stat.pixel_rdy = pixel_rdy;
        end
    end

endmodule

// File: hdl/frame_reader_pkg.sv
package frame_reader_pkg;

    `include "sdram_params.svh"

    // address and data widths
    localparam int ASIZE    = `SDRAM_ASIZE;
    localparam int RAW_W    = 10;
    localparam int PIX_W    = 8;
    localparam int STRIDE_W = 11;
    localparam int CPU_W    = 32;

    // sdram read timing, strobe to valid data
    localparam int RD_LATENCY = 2;
    localparam int LAT_W      = $clog2(RD_LATENCY + 1);

    // sensor constants
    localparam int BLACK_LEVEL = 16;
    localparam int LINE_PIXELS = 8;
    localparam int COL_W       = $clog2(LINE_PIXELS);

    // unused bits between the channels and the done flag
    localparam int PAD_W = CPU_W - 3 * PIX_W - 1;

    typedef struct packed {
        logic [RAW_W-1:0] raw;
        logic             last;
    } raw_sample_t;

    typedef struct packed {
        logic [PIX_W-1:0] red;
        logic [PIX_W-1:0] green;
        logic [PIX_W-1:0] blue;
        logic             last;
    } rgb_pixel_t;

    // readout word, pixel view
    typedef struct packed {
        logic [PIX_W-1:0] red;
        logic [PIX_W-1:0] green;
        logic [PIX_W-1:0] blue;
        logic [PAD_W-1:0] pad;
        logic             done;
    } cpu_pixel_view_t;

    // readout word, status view
    typedef struct packed {
        logic [CPU_W-3:0] zero;
        logic             busy;
        logic             pixel_rdy;
    } cpu_status_view_t;

    typedef union packed {
        cpu_pixel_view_t  pix;
        cpu_status_view_t stat;
    } cpu_word_u;

endpackage

// File: hdl/frame_reader_top.sv
`timescale 1ns/1ps

module frame_reader_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  img_captured,
    input  logic [frame_reader_pkg::ASIZE-1:0]    start_addr,
    input  logic [frame_reader_pkg::ASIZE-1:0]    max_addr,
    input  logic [frame_reader_pkg::STRIDE_W-1:0] rd_len,
    output logic                                  rd2_req,
    output logic [frame_reader_pkg::ASIZE-1:0]    rd2_addr,
    input  logic [frame_reader_pkg::RAW_W-1:0]    rd2_data,
    input  logic                                  ack,
    input  logic                                  reg_sel,
    output logic                                  pixel_rdy,
    output logic                                  img_done,
    output frame_reader_pkg::cpu_word_u           cpu_readdata
);

    // reader to demosaic
    frame_reader_pkg::raw_sample_t sample;
    logic                          sample_valid;
    logic                          frame_start;
    logic                          empty_frame;

    // demosaic to port
    frame_reader_pkg::rgb_pixel_t  pixel;
    logic                          pixel_valid;

    // port back to reader
    logic                          fetch;

    sdram_burst_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .img_captured (img_captured),
        .fetch        (fetch),
        .start_addr   (start_addr),
        .max_addr     (max_addr),
        .rd_len       (rd_len),
        .rd2_data     (rd2_data),
        .rd2_req      (rd2_req),
        .rd2_addr     (rd2_addr),
        .sample       (sample),
        .sample_valid (sample_valid),
        .frame_start  (frame_start),
        .empty_frame  (empty_frame)
    );

    bayer_line_demosaic u_demosaic (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_start  (frame_start),
        .sample       (sample),
        .sample_valid (sample_valid),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid)
    );

    cpu_pixel_port u_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .empty_frame  (empty_frame),
        .frame_start  (frame_start),
        .ack          (ack),
        .reg_sel      (reg_sel),
        .pixel_rdy    (pixel_rdy),
        .img_done     (img_done),
        .fetch        (fetch),
        .cpu_readdata (cpu_readdata)
    );

endmodule

// File: hdl/sdram_burst_reader.sv
`timescale 1ns/1ps

module sdram_burst_reader (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     img_captured,
    input  logic                                     fetch,
    input  logic [frame_reader_pkg::ASIZE-1:0]       start_addr,
    input  logic [frame_reader_pkg::ASIZE-1:0]       max_addr,
    input  logic [frame_reader_pkg::STRIDE_W-1:0]    rd_len,
    input  logic [frame_reader_pkg::RAW_W-1:0]       rd2_data,
    output logic                                     rd2_req,
    output logic [frame_reader_pkg::ASIZE-1:0]       rd2_addr,
    output frame_reader_pkg::raw_sample_t            sample,
    output logic                                     sample_valid,
    output logic                                     frame_start,
    output logic                                     empty_frame
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_CAPTURED
    } state_t;

    state_t                                   state;
    logic [frame_reader_pkg::ASIZE-1:0]       addr;
    logic [frame_reader_pkg::ASIZE-1:0]       next_addr;
    logic [frame_reader_pkg::LAT_W-1:0]       lat_cnt;
    logic                                     first_req;
    logic                                     capture;

    // end of frame test: address plus stride must stay below max_addr
    // one extra bit so the sum cannot wrap
    function automatic logic addr_fits(
        input logic [frame_reader_pkg::ASIZE-1:0]    a,
        input logic [frame_reader_pkg::STRIDE_W-1:0] stride,
        input logic [frame_reader_pkg::ASIZE-1:0]    limit
    );
        logic [frame_reader_pkg::ASIZE:0] sum;
        sum = {1'b0, a} + (frame_reader_pkg::ASIZE + 1)'(stride);
        return sum < {1'b0, limit};
    endfunction

    assign next_addr = addr + frame_reader_pkg::ASIZE'(rd_len);
    assign capture   = (state == ST_WAIT) && (lat_cnt == '0);

    // address is only looked at while rd2_req is high
    assign rd2_addr = addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            rd2_req      <= 1'b0;
            sample_valid <= 1'b0;
            frame_start  <= 1'b0;
            empty_frame  <= 1'b0;
            first_req    <= 1'b0;
            lat_cnt      <= '0;
            addr         <= '0;
        end else begin
            // strobes default low
            rd2_req      <= 1'b0;
            sample_valid <= 1'b0;
            frame_start  <= 1'b0;
            empty_frame  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (img_captured) begin
                        if (addr_fits(start_addr, rd_len, max_addr)) begin
                            addr      <= start_addr;
                            first_req <= 1'b1;
                            state     <= ST_ISSUE;
                        end else begin
                            // nothing to read, port reports done directly
                            empty_frame <= 1'b1;
                        end
                    end
                end
                ST_ISSUE: begin
                    rd2_req     <= 1'b1;
                    frame_start <= first_req;
                    first_req   <= 1'b0;
                    lat_cnt     <= frame_reader_pkg::LAT_W'(frame_reader_pkg::RD_LATENCY - 1);
                    state       <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (capture) begin
                        sample_valid <= 1'b1;
                        addr         <= next_addr;
                        // last sample frees the reader, port finishes the frame
                        if (addr_fits(next_addr, rd_len, max_addr)) begin
                            state <= ST_CAPTURED;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                ST_CAPTURED: begin
                    // one fetch outstanding at most, wait for the port
                    if (fetch) begin
                        state <= ST_ISSUE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // sample payload
    always_ff @(posedge clk) begin
        if (capture) begin
            sample.raw  <= rd2_data;
            sample.last <= !addr_fits(next_addr, rd_len, max_addr);
        end
    end

endmodule

// File: include/sdram_params.svh
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// sdram word address width
// shared with the controller side of the sdram
`define SDRAM_ASIZE 22

`endif

// File: tests/frame_reader_assertions.sv
`timescale 1ns/1ps

module frame_reader_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        rd2_req,
    input logic                        pixel_rdy,
    input logic                        img_done,
    input logic                        ack,
    input logic                        reg_sel,
    input logic                        frame_start,
    input frame_reader_pkg::cpu_word_u cpu_readdata
);

    // number of failed properties
    int   violations = 0;
    // a read has been issued and its pixel is not yet acked
    logic outstanding;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (rd2_req) begin
            outstanding <= 1'b1;
        end else if (ack && pixel_rdy) begin
            outstanding <= 1'b0;
        end
    end

    // outputs quiet one edge after reset is seen
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !rd2_req && !pixel_rdy && !img_done)
        else begin $error("outputs not low after reset"); violations++; end

    req_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd2_req |=> !rd2_req)
        else begin $error("rd2_req wider than one cycle"); violations++; end

    req_one_open: assert property (@(posedge clk) disable iff (!rst_n)
        rd2_req |-> !outstanding)
        else begin $error("rd2_req while a fetch is outstanding"); violations++; end

    // reader strobes two edges after the ack is sampled
    req_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
        rd2_req && !frame_start |-> $past(ack && pixel_rdy, 2))
        else begin $error("rd2_req without a preceding ack"); violations++; end

    rdy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_rdy && !ack |=> pixel_rdy)
        else begin $error("pixel_rdy dropped before ack"); violations++; end

    // pixel view must not move while offered
    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (pixel_rdy && !ack && reg_sel) ##1 reg_sel |-> $stable(cpu_readdata))
        else begin $error("pixel view changed before ack"); violations++; end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        img_done |=> !img_done)
        else begin $error("img_done wider than one cycle"); violations++; end

endmodule

bind frame_reader_top frame_reader_assertions u_checks (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd2_req      (rd2_req),
    .pixel_rdy    (pixel_rdy),
    .img_done     (img_done),
    .ack          (ack),
    .reg_sel      (reg_sel),
    .frame_start  (frame_start),
    .cpu_readdata (cpu_readdata)
);

// File: tests/frame_reader_tb.sv
`timescale 1ns/1ps

module frame_reader_tb;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  img_captured;
    logic [frame_reader_pkg::ASIZE-1:0]    start_addr;
    logic [frame_reader_pkg::ASIZE-1:0]    max_addr;
    logic [frame_reader_pkg::STRIDE_W-1:0] rd_len;
    logic                                  rd2_req;
    logic [frame_reader_pkg::ASIZE-1:0]    rd2_addr;
    logic [frame_reader_pkg::RAW_W-1:0]    rd2_data;
    logic                                  ack;
    logic                                  reg_sel;
    logic                                  pixel_rdy;
    logic                                  img_done;
    frame_reader_pkg::cpu_word_u           cpu_readdata;

    // addresses seen on the read port in the current frame
    int          got_addr[$];
    // img_done pulses seen in the current frame
    int          done_pulses;
    logic [31:0] seed;

    frame_reader_top UUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // frame buffer contents
    function automatic logic [frame_reader_pkg::RAW_W-1:0] sdram_word(input int addr);
        return frame_reader_pkg::RAW_W'(addr * 37);
    endfunction

    // subtract black level, clamp at zero, drop the low bits
    function automatic int black_corrected(input int raw);
        if (raw < frame_reader_pkg::BLACK_LEVEL) begin
            return 0;
        end
        return (raw - frame_reader_pkg::BLACK_LEVEL)
            >> (frame_reader_pkg::RAW_W - frame_reader_pkg::PIX_W);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    // one frame from trigger to done with processor side and scoreboard
    task automatic run_frame(input int start, input int stride, input int limit, input bit poke_mid);
        int                          exp_addr[$];
        int                          chan[3];
        int                          a;
        int                          waited;
        int                          delay;
        int                          col;
        int                          row;
        int                          c;
        frame_reader_pkg::cpu_word_u exp_word;
        // fetch rule
        a = start;
        while (a + stride < limit) begin
            exp_addr.push_back(a);
            a += stride;
        end
        chan = '{0, 0, 0};
        got_addr.delete();
        done_pulses = 0;
        @(posedge clk);
        start_addr   <= frame_reader_pkg::ASIZE'(start);
        max_addr     <= frame_reader_pkg::ASIZE'(limit);
        rd_len       <= frame_reader_pkg::STRIDE_W'(stride);
        img_captured <= 1'b1;
        @(posedge clk);
        img_captured <= 1'b0;
        if (exp_addr.size() == 0) begin
            do @(posedge clk); while (!img_done);
        end
        for (int k = 0; k < exp_addr.size(); k++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!pixel_rdy);
            // ack edge to next pixel_rdy is five cycles
            if (k > 0) begin
                assert (waited == 6)
                    else stop_on_error($sformatf("pixel %0d late by %0d", k, waited));
            end
            assert (got_addr.size() == k + 1 && got_addr[k] == exp_addr[k])
                else stop_on_error($sformatf("pixel %0d fetched from wrong address", k));
            assert (cpu_readdata == 32'h3)
                else stop_on_error("status view wrong while pixel offered");
            // bayer phase of pixel k
            col = k % frame_reader_pkg::LINE_PIXELS;
            row = (k / frame_reader_pkg::LINE_PIXELS) % 2;
            if (row == 0) begin
                c = (col % 2 == 0) ? 0 : 1;
            end else begin
                c = (col % 2 == 1) ? 2 : 1;
            end
            chan[c] = black_corrected(int'(sdram_word(exp_addr[k])));
            exp_word           = '0;
            exp_word.pix.red   = frame_reader_pkg::PIX_W'(chan[0]);
            exp_word.pix.green = frame_reader_pkg::PIX_W'(chan[1]);
            exp_word.pix.blue  = frame_reader_pkg::PIX_W'(chan[2]);
            reg_sel <= 1'b1;
            seed = xorshift32(seed);
            delay = int'(seed % 6);
            @(posedge clk);
            assert (cpu_readdata == exp_word)
                else stop_on_error($sformatf("pixel %0d read %h, expected %h",
                                             k, cpu_readdata, exp_word));
            repeat (delay) begin
                @(posedge clk);
                assert (pixel_rdy && cpu_readdata == exp_word)
                    else stop_on_error($sformatf("pixel %0d not held before ack", k));
            end
            ack     <= 1'b1;
            reg_sel <= 1'b0;
            if (poke_mid && k == 5) begin
                img_captured <= 1'b1;
            end
            @(posedge clk);
            ack          <= 1'b0;
            img_captured <= 1'b0;
        end
        if (exp_addr.size() > 0) begin
            @(posedge clk);
            assert (img_done) else stop_on_error("img_done missing after last ack");
        end
        reg_sel <= 1'b1;
        @(posedge clk);
        assert (cpu_readdata.pix.done) else stop_on_error("done bit not set after frame");
        reg_sel <= 1'b0;
        @(posedge clk);
        assert (cpu_readdata == '0) else stop_on_error("status not idle after frame");
        assert (got_addr.size() == exp_addr.size()) else stop_on_error("extra read requests");
        assert (done_pulses == 1) else stop_on_error("img_done did not pulse exactly once");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // sdram read port model
    // strobe seen at one edge and data driven for the next
    always @(posedge clk) begin
        if (rd2_req) begin
            rd2_data <= sdram_word(int'(rd2_addr));
            got_addr.push_back(int'(rd2_addr));
        end else begin
            rd2_data <= '1;
        end
    end

    // frame done pulses
    always @(posedge clk) begin
        if (img_done) begin
            done_pulses++;
        end
    end

    // bound assertion failures
    always @(negedge clk) begin
        if (UUT.u_checks.violations != 0) begin
            stop_on_error("a protocol assertion in the DUT failed");
        end
    end

    // 32 pixels in total at about 12 cycles each
    initial begin
        repeat ((20 + 12) * 12 + 300) @(posedge clk);
        $display("Run timed out, the frames did not complete in time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n        = 1'b0;
        img_captured = 1'b0;
        start_addr   = '0;
        max_addr     = '0;
        rd_len       = '0;
        rd2_data     = '0;
        ack          = 1'b0;
        reg_sel      = 1'b0;
        seed         = 32'ha67bbc01;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // idle after reset
        repeat (6) begin
            @(posedge clk);
            assert (!rd2_req && !pixel_rdy && !img_done && cpu_readdata == '0)
                else stop_on_error("outputs active while idle after reset");
        end
        // 20 pixels at stride 1
        // address 0 gives raw 0 for the clamp
        run_frame(0, 1, 21, 1'b0);
        // 12 pixels at stride 3 with the trigger repeated mid-frame
        run_frame(100, 3, 138, 1'b1);
        // first address already past the limit
        run_frame(500, 4, 503, 1'b0);
        repeat (4) @(posedge clk);
        if (UUT.u_checks.violations == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule
